//--- hdl/rom_check_geom_pkg.sv
// ROM geometry and digest sizes shared by every block of the boot-time ROM checker
`default_nettype none

package rom_check_geom_pkg;

  // Whole ROM in 32-bit words, with the expected digest in the top TopCount words
  localparam int unsigned RomDepth    = 32;
  localparam int unsigned TopCount    = 4;
  localparam int unsigned AddrWidth   = $clog2(RomDepth);
  localparam int unsigned IdxWidth    = $clog2(TopCount);
  localparam int unsigned DigestWidth = TopCount * 32;

  // Address boundaries used by the counter and the snoop path
  localparam logic [AddrWidth-1:0] TopStart    = AddrWidth'(RomDepth - TopCount);
  localparam logic [AddrWidth-1:0] LastLowAddr = AddrWidth'(RomDepth - TopCount - 1);
  localparam logic [AddrWidth-1:0] LastAddr    = AddrWidth'(RomDepth - 1);

  // Index of the final digest word
  localparam logic [IdxWidth-1:0] LastIdx = IdxWidth'(TopCount - 1);

endpackage

`default_nettype wire

//--- hdl/rom_check_ctrl_pkg.sv
// Control definitions for the ROM checker, the state encoding and the ROM read latency
`default_nettype none

package rom_check_ctrl_pkg;

  // Checker states in the order they are visited
  // RomAhead and DigestAhead cover the race between the top reads and the digest result
  typedef enum logic [2:0] {
    ReadingLow  = 3'd0,
    ReadingHigh = 3'd1,
    RomAhead    = 3'd2,
    DigestAhead = 3'd3,
    Checking    = 3'd4,
    Done        = 3'd5,
    Invalid     = 3'd6
  } check_state_e;

  // Cycles from a ROM request to its data on rom_data_i
  localparam int unsigned RomLatency = 1;

endpackage

`default_nettype wire

//--- hdl/rom_check_counter.sv
// Address generator for the ROM checker, issues reads and tracks the word being consumed
`default_nettype none

module rom_check_counter (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    data_rdy_i,
  output logic [rom_check_geom_pkg::AddrWidth-1:0] read_addr_o,
  output logic                                    read_req_o,
  output logic [rom_check_geom_pkg::AddrWidth-1:0] data_addr_o,
  output logic                                    data_last_low_o,
  output logic                                    done_o
);

  logic [rom_check_geom_pkg::AddrWidth-1:0]  req_addr_q;
  logic [rom_check_geom_pkg::AddrWidth-1:0]  data_addr_q;
  logic [rom_check_ctrl_pkg::RomLatency-1:0] inflight_q;
  logic [rom_check_ctrl_pkg::RomLatency-1:0] inflight_d;
  logic                                      req_done_q;
  logic                                      held_q;
  logic                                      done_q;
  logic                                      word_vld;
  logic                                      go;

  // A word is present when it arrives this cycle or arrived earlier and is still unconsumed
  assign word_vld = inflight_q[rom_check_ctrl_pkg::RomLatency-1] | held_q;
  assign go       = word_vld & data_rdy_i;

  // Only one word is ever outstanding, the next read goes out as the current word is taken
  assign read_req_o = ~req_done_q & (word_vld ? go : ~|inflight_q);

  // Shift register that marks when an issued read lands on the data port
  always_comb begin
    inflight_d    = inflight_q << 1;
    inflight_d[0] = read_req_o;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_addr_q  <= '0;
      data_addr_q <= '0;
      inflight_q  <= '0;
      req_done_q  <= 1'b0;
      held_q      <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      inflight_q <= inflight_d;
      held_q     <= word_vld & ~data_rdy_i;
      if (read_req_o) begin
        req_addr_q  <= req_addr_q + 1'b1;
        data_addr_q <= req_addr_q;
        req_done_q  <= req_addr_q == rom_check_geom_pkg::LastAddr;
      end
      // Sticky once the final top word has been taken
      if (go && data_addr_q == rom_check_geom_pkg::LastAddr) begin
        done_q <= 1'b1;
      end
    end
  end

  assign read_addr_o     = req_addr_q;
  assign data_addr_o     = data_addr_q;
  assign data_last_low_o = word_vld & (data_addr_q == rom_check_geom_pkg::LastLowAddr);
  assign done_o          = done_q;

endmodule

`default_nettype wire

//--- hdl/rom_check_digest.sv
// Rotate-and-XOR digest engine that folds the low ROM words streamed over valid/ready
`default_nettype none

module rom_check_digest (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      valid_i,
  input  logic                                      last_i,
  input  logic [31:0]                               data_i,
  output logic                                      ready_o,
  output logic                                      done_o,
  output logic [rom_check_geom_pkg::DigestWidth-1:0] digest_o
);

  logic [rom_check_geom_pkg::TopCount-1:0][31:0] acc_q;
  logic [rom_check_geom_pkg::IdxWidth-1:0]       cnt_q;
  logic                                          busy_q;
  logic                                          fin_q;
  logic                                          done_q;
  logic                                          xfer;

  // Each accepted word costs one mixing cycle with ready low
  assign ready_o = ~busy_q;
  assign xfer    = valid_i & ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q  <= '0;
      cnt_q  <= '0;
      busy_q <= 1'b0;
      fin_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      busy_q <= xfer;
      fin_q  <= xfer & last_i;
      // The second finalising cycle just presents the registered result
      done_q <= fin_q;
      if (xfer) begin
        // Word count wraps at TopCount, so successive words fill the digest round robin
        acc_q[cnt_q] <= {acc_q[cnt_q][30:0], acc_q[cnt_q][31]} ^ data_i;
        cnt_q        <= cnt_q + 1'b1;
      end
      // First finalising cycle, each word is tagged with its own index
      if (fin_q) begin
        for (int i = 0; i < rom_check_geom_pkg::TopCount; i++) begin
          acc_q[i] <= acc_q[i] ^ 32'(i);
        end
      end
    end
  end

  // Word 0 sits in the low bits and stays stable after done
  assign digest_o = acc_q;
  assign done_o   = done_q;

endmodule

`default_nettype wire

//--- hdl/rom_check_expected.sv
// Expected digest register file, filled from top-of-ROM words snooped during the scan
`default_nettype none

module rom_check_expected (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      wr_en_i,
  input  logic [rom_check_geom_pkg::IdxWidth-1:0]    wr_idx_i,
  input  logic [31:0]                               wr_data_i,
  output logic [rom_check_geom_pkg::DigestWidth-1:0] exp_digest_o
);

  // One 32-bit register per digest word, word 0 at the bottom
  logic [rom_check_geom_pkg::TopCount-1:0][31:0] exp_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_q <= '0;
    end else if (wr_en_i) begin
      // Top words arrive in address order, the index is relative to TopStart
      exp_q[wr_idx_i] <= wr_data_i;
    end
  end

  assign exp_digest_o = exp_q;

endmodule

`default_nettype wire

//--- hdl/rom_check_compare.sv
// Word-serial comparison of the computed digest against the expected digest
`default_nettype none

module rom_check_compare (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      start_i,
  input  logic [rom_check_geom_pkg::DigestWidth-1:0] digest_i,
  input  logic [rom_check_geom_pkg::DigestWidth-1:0] exp_digest_i,
  output logic                                      done_o,
  output logic                                      good_o
);

  logic [rom_check_geom_pkg::IdxWidth-1:0] idx_q;
  logic [rom_check_geom_pkg::IdxWidth-1:0] cur_idx;
  logic                                    run_q;
  logic                                    match_q;
  logic                                    done_q;
  logic                                    good_q;
  logic                                    active;
  logic                                    word_eq;
  logic                                    match_d;

  // Word 0 is compared in the start cycle itself, then one word per cycle
  assign active  = start_i | run_q;
  assign cur_idx = start_i ? '0 : idx_q;
  assign word_eq = digest_i[cur_idx*32 +: 32] == exp_digest_i[cur_idx*32 +: 32];
  // A fresh start ignores any earlier result
  assign match_d = (start_i | match_q) & word_eq;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q   <= '0;
      run_q   <= 1'b0;
      match_q <= 1'b0;
      done_q  <= 1'b0;
      good_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (active) begin
        match_q <= match_d;
        idx_q   <= cur_idx + 1'b1;
        run_q   <= cur_idx != rom_check_geom_pkg::LastIdx;
        // Good is latched with the final word and held from then on
        if (cur_idx == rom_check_geom_pkg::LastIdx) begin
          done_q <= 1'b1;
          good_q <= match_d;
        end
      end
    end
  end

  assign done_o = done_q;
  assign good_o = good_q;

endmodule

`default_nettype wire

//--- hdl/rom_check_fsm.sv
// Main state machine of the ROM checker, drives the stream, snoop, compare start and alert
`default_nettype none

module rom_check_fsm (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    counter_done_i,
  input  logic                                    counter_last_low_i,
  input  logic                                    counter_read_req_i,
  input  logic [rom_check_geom_pkg::AddrWidth-1:0] counter_data_addr_i,
  input  logic                                    stream_ready_i,
  input  logic                                    digest_done_i,
  input  logic                                    compare_done_i,
  output logic                                    stream_valid_o,
  output logic                                    stream_last_o,
  output logic                                    counter_data_rdy_o,
  output logic                                    snoop_en_o,
  output logic [rom_check_geom_pkg::IdxWidth-1:0]  snoop_idx_o,
  output logic                                    compare_start_o,
  output logic                                    rom_select_o,
  output logic                                    in_done_o,
  output logic                                    alert_o
);

  rom_check_ctrl_pkg::check_state_e         state_d;
  rom_check_ctrl_pkg::check_state_e         state_q;
  logic [rom_check_geom_pkg::AddrWidth-1:0] rel_addr;
  logic                                     fsm_alert;
  logic                                     in_done;
  logic                                     in_top;
  logic                                     xfer;
  logic                                     stream_valid_d;
  logic                                     stream_valid_q;
  logic                                     start_q;
  logic                                     counter_change;

  assign xfer    = stream_valid_q & stream_ready_i;
  assign in_done = state_q == rom_check_ctrl_pkg::Done;
  assign in_top  = state_q inside {rom_check_ctrl_pkg::ReadingHigh, rom_check_ctrl_pkg::DigestAhead};

  // The counter holds done from the last top word onwards, so a drop in Done means tampering
  assign counter_change = in_done & ~counter_done_i;

  // Linear sequence with one fork where the top reads race the digest result
  always_comb begin
    state_d   = state_q;
    fsm_alert = 1'b0;
    case (state_q)
      rom_check_ctrl_pkg::ReadingLow: begin
        if (counter_last_low_i && xfer) state_d = rom_check_ctrl_pkg::ReadingHigh;
      end
      rom_check_ctrl_pkg::ReadingHigh: begin
        case ({digest_done_i, counter_done_i})
          2'b01:   state_d = rom_check_ctrl_pkg::RomAhead;
          2'b10:   state_d = rom_check_ctrl_pkg::DigestAhead;
          2'b11:   state_d = rom_check_ctrl_pkg::Checking;
          default: state_d = state_q;
        endcase
      end
      rom_check_ctrl_pkg::RomAhead: begin
        if (digest_done_i) state_d = rom_check_ctrl_pkg::Checking;
      end
      rom_check_ctrl_pkg::DigestAhead: begin
        if (counter_done_i) state_d = rom_check_ctrl_pkg::Checking;
      end
      rom_check_ctrl_pkg::Checking: begin
        if (compare_done_i) state_d = rom_check_ctrl_pkg::Done;
      end
      // Terminal, the bus owns the ROM from here
      rom_check_ctrl_pkg::Done: state_d = state_q;
      // Invalid and any unencoded value stay trapped with the alert raised
      default: begin
        fsm_alert = 1'b1;
        state_d   = rom_check_ctrl_pkg::Invalid;
      end
    endcase

    // Done strobes that arrive in the wrong state mean the sequence was disturbed
    if ((compare_done_i && !(state_q inside {rom_check_ctrl_pkg::Checking,
                                             rom_check_ctrl_pkg::Done})) ||
        (counter_done_i && state_q == rom_check_ctrl_pkg::ReadingLow) ||
        (digest_done_i && !(state_q inside {rom_check_ctrl_pkg::ReadingHigh,
                                            rom_check_ctrl_pkg::RomAhead})) ||
        counter_change) begin
      state_d = rom_check_ctrl_pkg::Invalid;
    end
  end

  // Valid rises when a low word is requested and falls on its transfer
  // The request that follows the last low word targets the top, so it sets nothing
  always_comb begin
    stream_valid_d = stream_valid_q & ~stream_ready_i;
    if (counter_read_req_i && state_q == rom_check_ctrl_pkg::ReadingLow &&
        !counter_last_low_i) begin
      stream_valid_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= rom_check_ctrl_pkg::ReadingLow;
      stream_valid_q <= 1'b0;
      start_q        <= 1'b0;
    end else begin
      state_q        <= state_d;
      stream_valid_q <= stream_valid_d;
      // Single pulse in the first Checking cycle
      start_q        <= (state_q != rom_check_ctrl_pkg::Checking) &&
                        (state_d == rom_check_ctrl_pkg::Checking);
    end
  end

  // Top words are taken as soon as they return, each lands at its offset from TopStart
  assign rel_addr           = counter_data_addr_i - rom_check_geom_pkg::TopStart;
  assign snoop_idx_o        = rel_addr[rom_check_geom_pkg::IdxWidth-1:0];
  assign snoop_en_o         = in_top & ~counter_done_i;
  assign counter_data_rdy_o = xfer | in_top;

  assign stream_valid_o  = stream_valid_q;
  assign stream_last_o   = stream_valid_q & counter_last_low_i;
  assign compare_start_o = start_q;
  assign rom_select_o    = in_done;
  assign in_done_o       = in_done;
  assign alert_o         = fsm_alert | counter_change;

endmodule

`default_nettype wire

//--- hdl/rom_check_top.sv
// Top level of the boot-time ROM checker that scans the ROM after reset and then hands it to the bus
`default_nettype none

module rom_check_top (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  output logic                                      rom_req_o,
  output logic [rom_check_geom_pkg::AddrWidth-1:0]   rom_addr_o,
  input  logic [31:0]                               rom_data_i,
  output logic                                      rom_select_o,
  output logic                                      done_o,
  output logic                                      good_o,
  output logic [rom_check_geom_pkg::DigestWidth-1:0] digest_o,
  output logic                                      digest_valid_o,
  output logic                                      alert_o
);

  logic [rom_check_geom_pkg::AddrWidth-1:0]   data_addr;
  logic [rom_check_geom_pkg::IdxWidth-1:0]    snoop_idx;
  logic [rom_check_geom_pkg::DigestWidth-1:0] exp_digest;
  logic                                       counter_done;
  logic                                       last_low;
  logic                                       data_rdy;
  logic                                       stream_valid;
  logic                                       stream_last;
  logic                                       stream_ready;
  logic                                       digest_done;
  logic                                       snoop_en;
  logic                                       compare_start;
  logic                                       compare_done;
  logic                                       compare_good;
  logic                                       in_done;

  rom_check_counter u_counter (
    .clk_i, .rst_ni, .data_rdy_i(data_rdy), .read_addr_o(rom_addr_o), .read_req_o(rom_req_o),
    .data_addr_o(data_addr), .data_last_low_o(last_low), .done_o(counter_done)
  );

  // Low words go straight from the ROM data port into the digest engine
  rom_check_digest u_digest (
    .clk_i, .rst_ni, .valid_i(stream_valid), .last_i(stream_last), .data_i(rom_data_i),
    .ready_o(stream_ready), .done_o(digest_done), .digest_o(digest_o)
  );

  rom_check_expected u_expected (
    .clk_i, .rst_ni, .wr_en_i(snoop_en), .wr_idx_i(snoop_idx), .wr_data_i(rom_data_i),
    .exp_digest_o(exp_digest)
  );

  rom_check_compare u_compare (
    .clk_i, .rst_ni, .start_i(compare_start), .digest_i(digest_o), .exp_digest_i(exp_digest),
    .done_o(compare_done), .good_o(compare_good)
  );

  rom_check_fsm u_fsm (
    .clk_i, .rst_ni, .counter_done_i(counter_done), .counter_last_low_i(last_low),
    .counter_read_req_i(rom_req_o), .counter_data_addr_i(data_addr),
    .stream_ready_i(stream_ready), .digest_done_i(digest_done),
    .compare_done_i(compare_done), .stream_valid_o(stream_valid), .stream_last_o(stream_last),
    .counter_data_rdy_o(data_rdy), .snoop_en_o(snoop_en), .snoop_idx_o(snoop_idx),
    .compare_start_o(compare_start), .rom_select_o(rom_select_o), .in_done_o(in_done),
    .alert_o(alert_o)
  );

  // The key consumer and the boot flow only see results once the FSM reaches Done
  assign done_o         = in_done;
  assign good_o         = in_done & compare_good;
  assign digest_valid_o = in_done;

endmodule

`default_nettype wire

//--- sim/rom_check_tb.sv
// Self-checking testbench for the ROM checker, models the ROM and replays the trace file
`default_nettype none

module rom_check_tb;

  localparam int unsigned ClkPeriod     = 100;
  localparam int unsigned InDelay       = 10;
  localparam int unsigned ResetCycles   = 4;
  localparam int unsigned TimeoutMargin = 20;
  localparam logic [31:0] LfsrSeed      = 32'd79;
  localparam int unsigned Depth         = rom_check_geom_pkg::RomDepth;
  localparam int unsigned Top           = rom_check_geom_pkg::TopCount;
  localparam int unsigned LowWords      = Depth - Top;
  localparam int unsigned DigestBits    = rom_check_geom_pkg::DigestWidth;

  logic                                     clk;
  logic                                     rst_n;
  logic                                     rom_req;
  logic [rom_check_geom_pkg::AddrWidth-1:0] rom_addr;
  logic [31:0]                              rom_data;
  logic                                     rom_select;
  logic                                     done;
  logic                                     good;
  logic [DigestBits-1:0]                    digest;
  logic                                     digest_valid;
  logic                                     alert;

  // ROM contents and the request seen at the last falling edge
  logic [31:0]                              rom_mem [Depth];
  logic                                     req_seen;
  logic [rom_check_geom_pkg::AddrWidth-1:0] addr_seen;
  int unsigned                              req_count;
  int unsigned                              cycle_cnt;
  int unsigned                              timeout_limit;
  string                                    cur_name;

  // One entry per trace row
  string                                    names [$];
  string                                    corrupts [$];
  logic                                     goods [$];
  logic [DigestBits-1:0]                    digests [$];

  rom_check_top u_rom_check_top (
    .clk_i(clk), .rst_ni(rst_n), .rom_req_o(rom_req), .rom_addr_o(rom_addr),
    .rom_data_i(rom_data), .rom_select_o(rom_select), .done_o(done), .good_o(good),
    .digest_o(digest), .digest_valid_o(digest_valid), .alert_o(alert)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string what, input logic [DigestBits-1:0] expected,
                             input logic [DigestBits-1:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %0h, actual %0h", what, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "Mismatch in %s", what);
    end
  endtask

  // Taps on the two lowest stages, the new bit enters at the top
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[0] ^ state[1], state[31:1]};
  endfunction

  // Every image starts from the seed, bit 0 of each word is taken first
  task automatic fill_low();
    logic [31:0] lfsr;
    lfsr = LfsrSeed;
    for (int a = 0; a < LowWords; a++) begin
      for (int b = 0; b < 32; b++) begin
        rom_mem[a][b] = lfsr[0];
        lfsr = lfsr_next(lfsr);
      end
    end
  endtask

  // Low word k lands in digest word k mod Top, rotated left by one before the XOR
  function automatic logic [DigestBits-1:0] fold_digest();
    logic [Top-1:0][31:0] acc;
    acc = '0;
    for (int k = 0; k < LowWords; k++) begin
      acc[k % Top] = {acc[k % Top][30:0], acc[k % Top][31]} ^ rom_mem[k];
    end
    for (int i = 0; i < Top; i++) begin
      acc[i] = acc[i] ^ 32'(i);
    end
    return acc;
  endfunction

  task automatic read_trace();
    int          fd;
    int          ch;
    int          fields;
    int          good_flag;
    string       tok;
    string       corrupt;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] d2;
    logic [31:0] d3;
    fd = $fopen("sim/rom_check_trace.txt", "r");
    if (fd == 0) abort_run("Could not open the trace file sim/rom_check_trace.txt");
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok.getc(0) == "#") begin
        // Comment line, drop the rest of it
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1) ch = $fgetc(fd);
      end else begin
        fields = $fscanf(fd, "%s %d %h %h %h %h", corrupt, good_flag, d0, d1, d2, d3);
        if (fields != 6) abort_run("Trace row is incomplete");
        names.push_back(tok);
        corrupts.push_back(corrupt);
        goods.push_back(good_flag[0]);
        digests.push_back({d3, d2, d1, d0});
      end
    end
    $fclose(fd);
  endtask

  // ROM model, the data of a request appears one cycle later and stays until the next one
  always @(posedge clk) begin
    #InDelay;
    if (req_seen) rom_data = rom_mem[addr_seen];
  end

  // Bus monitor, sampled at the falling edge where the DUT outputs are settled
  always @(negedge clk) begin
    req_seen  = rst_n & rom_req;
    addr_seen = rom_addr;
    if (rst_n) begin
      if (alert) abort_run("Alert raised during the ROM check");
      if (rom_select !== done) abort_run("ROM select does not follow done");
      if (rom_req) begin
        if (done) abort_run("ROM request issued after the port went to the bus");
        check_value({cur_name, " request address"}, req_count, rom_addr);
        req_count++;
      end
    end
  end

  // Watchdog on the whole run
  always @(posedge clk) begin
    cycle_cnt++;
    if (timeout_limit != 0 && cycle_cnt > timeout_limit) begin
      abort_run("Timeout, the checker did not reach done in time");
    end
  end

  initial begin
    logic [DigestBits-1:0] model;
    string                 corrupt;
    rst_n         = 1'b0;
    rom_data      = '0;
    req_seen      = 1'b0;
    addr_seen     = '0;
    req_count     = 0;
    cycle_cnt     = 0;
    timeout_limit = 0;
    cur_name      = "reset";
    read_trace();
    timeout_limit = names.size() * (3 * Depth + Top + TimeoutMargin);
    foreach (names[t]) begin
      cur_name = names[t];
      corrupt  = corrupts[t];
      @(posedge clk);
      #InDelay;
      rst_n = 1'b0;
      // The image is rebuilt while the DUT sits in reset
      fill_low();
      model = fold_digest();
      check_value({cur_name, " model digest"}, digests[t], model);
      for (int i = 0; i < Top; i++) rom_mem[LowWords + i] = model[i*32 +: 32];
      if (corrupt == "low") begin
        rom_mem[0][0] = ~rom_mem[0][0];
      end else if (corrupt != "none") begin
        rom_mem[LowWords + corrupt.atoi()][0] = ~rom_mem[LowWords + corrupt.atoi()][0];
      end
      req_count = 0;
      repeat (ResetCycles) @(posedge clk);
      #InDelay;
      rst_n = 1'b1;
      @(negedge clk);
      check_value({cur_name, " done_o after reset"}, 0, done);
      check_value({cur_name, " good_o after reset"}, 0, good);
      check_value({cur_name, " digest_valid_o after reset"}, 0, digest_valid);
      check_value({cur_name, " alert_o after reset"}, 0, alert);
      while (!done) @(negedge clk);
      check_value({cur_name, " good_o"}, goods[t], good);
      check_value({cur_name, " digest_valid_o"}, 1, digest_valid);
      // A corrupted low word changes the digest away from the stored top words
      if (corrupt == "low") begin
        check_value({cur_name, " digest_o differs"}, 1, digest != digests[t]);
      end else begin
        check_value({cur_name, " digest_o"}, digests[t], digest);
      end
      check_value({cur_name, " request count"}, Depth, req_count);
      // A few idle cycles let the monitor see the port stay with the bus
      repeat (4) @(negedge clk);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- Bender.yml
package:
  name: rom_check

sources:
  # Packages come first, every RTL block refers to them
  - hdl/rom_check_geom_pkg.sv
  - hdl/rom_check_ctrl_pkg.sv
  - hdl/rom_check_counter.sv
  - hdl/rom_check_digest.sv
  - hdl/rom_check_expected.sv
  - hdl/rom_check_compare.sv
  - hdl/rom_check_fsm.sv
  - hdl/rom_check_top.sv
  - target: test
    files:
      - sim/rom_check_tb.sv

//--- tb.f
hdl/rom_check_geom_pkg.sv
hdl/rom_check_ctrl_pkg.sv
hdl/rom_check_counter.sv
hdl/rom_check_digest.sv
hdl/rom_check_expected.sv
hdl/rom_check_compare.sv
hdl/rom_check_fsm.sv
hdl/rom_check_top.sv
sim/rom_check_tb.sv

//--- sim/rom_check_trace.txt
# Columns: test name, corrupted word (none, top index 0 to 3, or low), expected good_o,
# then the expected digest words 0 to 3 in hex
clean        none  1  9d1575fd d39fcf3d ba5028b5 67783cef
top_word_0   0     0  9d1575fd d39fcf3d ba5028b5 67783cef
top_word_1   1     0  9d1575fd d39fcf3d ba5028b5 67783cef
top_word_2   2     0  9d1575fd d39fcf3d ba5028b5 67783cef
top_word_3   3     0  9d1575fd d39fcf3d ba5028b5 67783cef
low_word     low   0  9d1575fd d39fcf3d ba5028b5 67783cef
clean_again  none  1  9d1575fd d39fcf3d ba5028b5 67783cef
